/* ttc_pkg.sv */
// Shared constants for the single-channel counter; 16-bit APB data, no wait states, bit 5 reserved
package ttc_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int count_w = 16;  // Counter and compare width
  localparam int addr_w  = 8;   // APB address
  localparam int data_w  = 16;  // APB data
  localparam int intr_w  = 6;   // Interrupt and enable words

  // Count, interval and match values
  typedef logic [count_w-1:0] count_t;
  // Interrupt status and enable words
  typedef logic [intr_w-1:0]  intr_t;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam logic [addr_w-1:0] ctrl_addr     = 8'h00;
  localparam logic [addr_w-1:0] interval_addr = 8'h04;
  localparam logic [addr_w-1:0] match1_addr   = 8'h08;
  localparam logic [addr_w-1:0] match2_addr   = 8'h0C;
  localparam logic [addr_w-1:0] match3_addr   = 8'h10;
  localparam logic [addr_w-1:0] count_addr    = 8'h14;  // Read only
  localparam logic [addr_w-1:0] intr_addr     = 8'h18;  // Read clears
  localparam logic [addr_w-1:0] intr_en_addr  = 8'h1C;

  // ------------------------------------------------
  // Control register bits
  // ------------------------------------------------
  localparam int ctrl_en_bit       = 0;  // Count enable
  localparam int ctrl_interval_bit = 1;  // Interval mode
  localparam int ctrl_match_bit    = 2;  // Match enable
  localparam int ctrl_restart_bit  = 3;  // Write one to restart, reads 0

  // ------------------------------------------------
  // Interrupt word bits
  // ------------------------------------------------
  // Bit 5 has no source and stays 0
  localparam int intr_interval_bit = 0;
  localparam int intr_match1_bit   = 1;
  localparam int intr_match2_bit   = 2;
  localparam int intr_match3_bit   = 3;
  localparam int intr_overflow_bit = 4;

endpackage

/* ttc_count_if.sv */
// Control and event bundle for one counter channel; event pulses are one cycle wide
interface ttc_count_if;

  // Control from the register block
  logic            count_en;        // Count enable
  logic            interval_mode;   // Wrap at interval_val
  logic            match_en;        // Comparators active
  logic            restart;         // One-cycle restart
  ttc_pkg::count_t interval_val;
  ttc_pkg::count_t match_val [1:3];

  // Status and events from the counter
  ttc_pkg::count_t count_val;
  logic            interval_intr;   // Interval wrap
  logic [3:1]      match_intr;      // Per comparator
  logic            overflow_intr;   // Free-running wrap

  modport regs (
    output count_en, interval_mode, match_en, restart, interval_val, match_val,
    input  count_val
  );

  modport counter (
    input  count_en, interval_mode, match_en, restart, interval_val, match_val,
    output count_val, interval_intr, match_intr, overflow_intr
  );

  modport intr (
    input interval_intr, match_intr, overflow_intr
  );

endinterface

/* ttc_regs.sv */
// APB register block; two-cycle transfers only, no pready or pslverr, prdata 0 outside access
module ttc_regs (
  input  logic                         pclk10,
  input  logic                         n_p_reset10,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [ttc_pkg::addr_w-1:0]   paddr,
  input  logic [ttc_pkg::data_w-1:0]   pwdata,
  input  ttc_pkg::intr_t               intr_status,
  input  ttc_pkg::intr_t               intr_en,
  output logic [ttc_pkg::data_w-1:0]   prdata,
  output logic                         intr_en_sel,
  output logic                         clear_interrupt,
  output ttc_pkg::intr_t               wdata,
  ttc_count_if.regs                    cnt
);

  // ------------------------------------------------
  // Access phase decode
  // ------------------------------------------------
  logic wr_en;  // Write access phase
  logic rd_en;  // Read access phase

  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & penable & ~pwrite;

  // Control and compare registers
  logic            ctrl_en_q;
  logic            ctrl_interval_q;
  logic            ctrl_match_q;
  logic            restart_q;       // Restart pulse, one cycle after the write
  ttc_pkg::count_t interval_q;
  ttc_pkg::count_t match_q [1:3];

  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      ctrl_en_q       <= 1'b0;
      ctrl_interval_q <= 1'b0;
      ctrl_match_q    <= 1'b0;
      restart_q       <= 1'b0;
      interval_q      <= '0;
      match_q[1]      <= '0;
      match_q[2]      <= '0;
      match_q[3]      <= '0;
    end
    else
    begin
      restart_q <= 1'b0;  // Self clearing
      if (wr_en)
      begin
        case (paddr)
          ttc_pkg::ctrl_addr:
          begin
            ctrl_en_q       <= pwdata[ttc_pkg::ctrl_en_bit];
            ctrl_interval_q <= pwdata[ttc_pkg::ctrl_interval_bit];
            ctrl_match_q    <= pwdata[ttc_pkg::ctrl_match_bit];
            restart_q       <= pwdata[ttc_pkg::ctrl_restart_bit];
          end
          ttc_pkg::interval_addr: interval_q <= pwdata;
          ttc_pkg::match1_addr:   match_q[1] <= pwdata;
          ttc_pkg::match2_addr:   match_q[2] <= pwdata;
          ttc_pkg::match3_addr:   match_q[3] <= pwdata;
          default: ;  // Read-only or unmapped
        endcase
      end
    end
  end

  // To the counter
  assign cnt.count_en      = ctrl_en_q;
  assign cnt.interval_mode = ctrl_interval_q;
  assign cnt.match_en      = ctrl_match_q;
  assign cnt.restart       = restart_q;
  assign cnt.interval_val  = interval_q;
  assign cnt.match_val[1]  = match_q[1];
  assign cnt.match_val[2]  = match_q[2];
  assign cnt.match_val[3]  = match_q[3];

  // To the interrupt block, both in the access phase
  assign intr_en_sel     = wr_en & (paddr == ttc_pkg::intr_en_addr);
  assign clear_interrupt = rd_en & (paddr == ttc_pkg::intr_addr);
  assign wdata           = pwdata[ttc_pkg::intr_w-1:0];

  // ------------------------------------------------
  // Read mux
  // ------------------------------------------------
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        ttc_pkg::ctrl_addr:
        begin
          prdata[ttc_pkg::ctrl_en_bit]       = ctrl_en_q;
          prdata[ttc_pkg::ctrl_interval_bit] = ctrl_interval_q;
          prdata[ttc_pkg::ctrl_match_bit]    = ctrl_match_q;
        end
        ttc_pkg::interval_addr: prdata = interval_q;
        ttc_pkg::match1_addr:   prdata = match_q[1];
        ttc_pkg::match2_addr:   prdata = match_q[2];
        ttc_pkg::match3_addr:   prdata = match_q[3];
        ttc_pkg::count_addr:    prdata = cnt.count_val;
        ttc_pkg::intr_addr:     prdata[ttc_pkg::intr_w-1:0] = intr_status;  // Pre-clear value
        ttc_pkg::intr_en_addr:  prdata[ttc_pkg::intr_w-1:0] = intr_en;
        default: ;
      endcase
    end
  end

  // A status read and an enable write cannot share one transfer
  a_sel_exclusive: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    !(clear_interrupt && intr_en_sel));

endmodule

/* ttc_counter.sv */
// Single 16-bit up-counter, no prescaler; event pulses are registered and one cycle wide
module ttc_counter (
  input  logic       pclk10,
  input  logic       n_p_reset10,
  ttc_count_if.counter cnt
);

  ttc_pkg::count_t count_q;     // Current count
  logic            interval_q;  // Interval wrap event
  logic            overflow_q;  // Free-running wrap event
  logic [3:1]      match_q;     // Comparator events

  // ------------------------------------------------
  // Wrap and compare detection
  // ------------------------------------------------
  logic       at_interval;  // Count reached interval_val
  logic       at_max;       // Count at all ones
  logic [3:1] match_hit;    // Equality per comparator

  assign at_interval = cnt.interval_mode & (count_q == cnt.interval_val);
  assign at_max      = ~cnt.interval_mode & (count_q == '1);

  always_comb
  begin
    for (int n = 1; n <= 3; n++)
    begin
      match_hit[n] = cnt.match_en & (count_q == cnt.match_val[n]);
    end
  end

  // ------------------------------------------------
  // Count and event registers
  // ------------------------------------------------
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      count_q    <= '0;
      interval_q <= 1'b0;
      overflow_q <= 1'b0;
      match_q    <= '0;
    end
    else
    begin
      // Pulses drop unless re-raised below
      interval_q <= 1'b0;
      overflow_q <= 1'b0;
      match_q    <= '0;
      if (cnt.restart)
      begin
        count_q <= '0;  // Silent restart, no event
      end
      else if (cnt.count_en)
      begin
        match_q <= match_hit;  // Pulse in the cycle after equality
        if (at_interval)
        begin
          count_q    <= '0;
          interval_q <= 1'b1;
        end
        else if (at_max)
        begin
          count_q    <= '0;
          overflow_q <= 1'b1;
        end
        else
        begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  assign cnt.count_val     = count_q;
  assign cnt.interval_intr = interval_q;
  assign cnt.overflow_intr = overflow_q;
  assign cnt.match_intr    = match_q;

  // Only one kind of wrap per cycle
  a_one_wrap: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    !(cnt.interval_intr && cnt.overflow_intr));

  // Overflow pulse never seen while interval mode is set
  a_no_ovf_interval: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    cnt.overflow_intr |-> !cnt.interval_mode);

endmodule

/* ttc_interrupt.sv */
// Sticky interrupt status; events must be single pulses, status clears on read unless just set
module ttc_interrupt (
  input  logic           pclk10,
  input  logic           n_p_reset10,
  input  logic           intr_en_sel,
  input  logic           clear_interrupt,
  input  ttc_pkg::intr_t wdata,
  ttc_count_if.intr      cnt,
  output logic           interrupt,
  output ttc_pkg::intr_t intr_status,
  output ttc_pkg::intr_t intr_en
);

  ttc_pkg::intr_t intr_detect;  // Packed event pulses
  ttc_pkg::intr_t evt_q;        // First register stage
  ttc_pkg::intr_t sync_q;       // Delayed copy for edge detect
  ttc_pkg::intr_t capture_q;    // Rising-edge captures
  ttc_pkg::intr_t status_q;     // Sticky status
  ttc_pkg::intr_t en_q;         // Enable mask
  logic           intr_set_q;   // Capture seen last cycle, blocks clear

  // Reserved top bit left at 0
  always_comb
  begin
    intr_detect                             = '0;
    intr_detect[ttc_pkg::intr_interval_bit] = cnt.interval_intr;
    intr_detect[ttc_pkg::intr_match1_bit]   = cnt.match_intr[1];
    intr_detect[ttc_pkg::intr_match2_bit]   = cnt.match_intr[2];
    intr_detect[ttc_pkg::intr_match3_bit]   = cnt.match_intr[3];
    intr_detect[ttc_pkg::intr_overflow_bit] = cnt.overflow_intr;
  end

  // ------------------------------------------------
  // Capture and sticky status
  // ------------------------------------------------
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      evt_q      <= '0;
      sync_q     <= '0;
      capture_q  <= '0;
      status_q   <= '0;
      intr_set_q <= 1'b0;
    end
    else
    begin
      evt_q      <= intr_detect;
      sync_q     <= evt_q;
      capture_q  <= evt_q & ~sync_q;  // Rising edges only
      intr_set_q <= |capture_q;
      // Clear keeps what is captured at the same edge
      if (clear_interrupt && !intr_set_q)
        status_q <= capture_q & en_q;
      else
        status_q <= status_q | (capture_q & en_q);
    end
  end

  // Enable register, written whole
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      en_q <= '0;
    else if (intr_en_sel)
      en_q <= wdata;
  end

  assign intr_status = status_q;
  assign intr_en     = en_q;
  assign interrupt   = |status_q;  // Any enabled, unread event

  // No event source feeds the reserved bit
  a_rsvd_zero: assert property (@(posedge pclk10) disable iff (!n_p_reset10)
    intr_status[ttc_pkg::intr_w-1] == 1'b0);

endmodule

/* ttc_top.sv */
// Lite timer top level, one counter channel; APB transfers are fixed at two cycles
module ttc_top (
  input  logic                       pclk10,
  input  logic                       n_p_reset10,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [ttc_pkg::addr_w-1:0] paddr,
  input  logic [ttc_pkg::data_w-1:0] pwdata,
  output logic [ttc_pkg::data_w-1:0] prdata,
  output logic                       interrupt
);

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------
  ttc_count_if    cnt_if ();      // Counter control and events
  logic           intr_en_sel;    // Enable register write
  logic           clear_interrupt;  // Status read
  ttc_pkg::intr_t wdata;          // Enable write data
  ttc_pkg::intr_t intr_status;    // Status readback
  ttc_pkg::intr_t intr_en;        // Enable readback

  ttc_regs u_regs (
    .pclk10          (pclk10),
    .n_p_reset10     (n_p_reset10),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .intr_status     (intr_status),
    .intr_en         (intr_en),
    .prdata          (prdata),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt),
    .wdata           (wdata),
    .cnt             (cnt_if)
  );

  ttc_counter u_counter (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .cnt         (cnt_if)
  );

  ttc_interrupt u_interrupt (
    .pclk10          (pclk10),
    .n_p_reset10     (n_p_reset10),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt),
    .wdata           (wdata),
    .cnt             (cnt_if),
    .interrupt       (interrupt),
    .intr_status     (intr_status),
    .intr_en         (intr_en)
  );

endmodule

/* tb_ttc_top.sv */
// Vector-driven testbench; run from the project root so ttc_vectors.txt is found, 8 ns clock
module tb_ttc_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_half  = 4;  // Half of the 8 ns period
  localparam int max_slack = 3;  // Random idle cycles between operations

  logic                       pclk10;
  logic                       n_p_reset10;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [ttc_pkg::addr_w-1:0] paddr;
  logic [ttc_pkg::data_w-1:0] pwdata;
  logic [ttc_pkg::data_w-1:0] prdata;
  logic                       interrupt;

  // Vector table, one entry per file line
  string       v_name [$];
  byte         v_op   [$];
  int unsigned v_addr [$];
  int unsigned v_data [$];
  int unsigned v_exp  [$];

  int                         pass_cnt;
  int                         fail_cnt;
  bit                         armed;         // Watchdog start
  longint unsigned            limit_cycles;
  logic [ttc_pkg::data_w-1:0] rdata;

  ttc_top u_ttc_top (
    .pclk10      (pclk10),
    .n_p_reset10 (n_p_reset10),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .interrupt   (interrupt)
  );

  always #clk_half pclk10 = ~pclk10;

  // --------------------------------------------------
  // Vector file
  // --------------------------------------------------
  task automatic load_vectors();
    int          fd;
    string       line;
    string       name;
    string       op;
    int unsigned a;
    int unsigned d;
    int unsigned e;
    fd = $fopen("ttc_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file ttc_vectors.txt");
      fail_cnt++;
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line[0] == 8'h23)  // Blank or # comment
        continue;
      if ($sscanf(line, "%s %s %h %h %h", name, op, a, d, e) == 5)
      begin
        v_name.push_back(name);
        v_op.push_back(op[0]);
        v_addr.push_back(a);
        v_data.push_back(d);
        v_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // Setup then access, read data sampled mid access phase
  task automatic apb_xfer(input logic wr, input int unsigned addr, input int unsigned wd,
                          output logic [ttc_pkg::data_w-1:0] rd);
    @(negedge pclk10);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = ttc_pkg::addr_w'(addr);
    pwdata  = ttc_pkg::data_w'(wd);
    @(negedge pclk10);
    penable = 1'b1;
    #(clk_half / 2);
    rd = prdata;
    @(negedge pclk10);  // Access ended at the posedge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input logic [ttc_pkg::data_w-1:0] exp,
                            input logic [ttc_pkg::data_w-1:0] act);
    if (act === exp)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else
    begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic check_bound(input string name, input logic [ttc_pkg::data_w-1:0] bound,
                             input logic [ttc_pkg::data_w-1:0] act);
    if (!$isunknown(act) && act < bound)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else
    begin
      $display("Fail %s expected below %h actual %h", name, bound, act);
      fail_cnt++;
    end
  endtask

  task automatic check_intr(input string name, input logic exp, input logic act);
    if (act === exp)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else
    begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      fail_cnt++;
    end
  endtask

  // Longest idle run sets the time budget
  initial
  begin
    wait (armed);
    repeat (limit_cycles) @(posedge pclk10);
    $display("Watchdog: the run timed out after %0d cycles", limit_cycles);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Replay
  // --------------------------------------------------
  initial
  begin
    int unsigned max_idle;
    pclk10      = 1'b0;
    n_p_reset10 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    max_idle    = max_slack;
    void'($urandom(32'h29fb));
    load_vectors();
    foreach (v_op[i])
      if (v_op[i] == "I" && v_data[i] > max_idle)
        max_idle = v_data[i];
    limit_cycles = longint'(v_op.size() + 1) * (max_idle + 8) + 8;
    armed = 1'b1;
    repeat (4) @(negedge pclk10);  // Reset held 4 cycles
    n_p_reset10 = 1'b1;
    foreach (v_op[i])
    begin
      case (v_op[i])
        "W": apb_xfer(1'b1, v_addr[i], v_data[i], rdata);
        "R":
        begin
          apb_xfer(1'b0, v_addr[i], 0, rdata);
          check_data(v_name[i], ttc_pkg::data_w'(v_exp[i]), rdata);
        end
        "L":
        begin
          apb_xfer(1'b0, v_addr[i], 0, rdata);
          check_bound(v_name[i], ttc_pkg::data_w'(v_exp[i]), rdata);
        end
        "I":
        begin
          repeat (v_data[i]) @(negedge pclk10);
          check_intr(v_name[i], v_exp[i][0], interrupt);
        end
        default:
        begin
          $display("Unknown operation in vector %s", v_name[i]);
          fail_cnt++;
        end
      endcase
      repeat ($urandom_range(max_slack)) @(negedge pclk10);  // Timing slack
    end
    $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* ttc_vectors.txt */
# name op addr data expected, all numbers hex
# op W write, R read exact, L read below expected, I idle data cycles then interrupt level
regs_interval W 04 0014 0000
regs_interval R 04 0000 0014
regs_match1   W 08 0005 0000
regs_match1   R 08 0000 0005
regs_match2   W 0C 0007 0000
regs_match2   R 0C 0000 0007
regs_match3   W 10 1234 0000
regs_match3   R 10 0000 1234
regs_intr_en  W 1C 003F 0000
regs_intr_en  R 1C 0000 003F
regs_ctrl     W 00 000E 0000
regs_ctrl     R 00 0000 0006
regs_count    R 14 0000 0000
ival_en       W 1C 0001 0000
ival_start    W 00 0003 0000
ival_run      I 00 0064 0001
ival_stop     W 00 0000 0000
ival_drain    I 00 0006 0001
ival_status   R 18 0000 0001
ival_cleared  R 18 0000 0000
ival_low      I 00 0002 0000
match_en      W 1C 0004 0000
match_start   W 00 000D 0000
match_run     I 00 0014 0001
match_status  R 18 0000 0004
ovf_en        W 1C 0010 0000
ovf_start     W 00 0009 0000
ovf_run       I 00 10040 0001
ovf_stop      W 00 0000 0000
ovf_hold      I 00 0004 0001
ovf_status    R 18 0000 0010
ovf_low       I 00 0002 0000
rst_en        W 1C 001F 0000
rst_run       W 00 0001 0000
rst_counting  I 00 0032 0000
rst_restart   W 00 0009 0000
rst_stop      W 00 0000 0000
rst_count     L 14 0000 0008
rst_status    R 18 0000 0000

/* verilog.f */
ttc_pkg.sv
ttc_count_if.sv
ttc_regs.sv
ttc_counter.sv
ttc_interrupt.sv
ttc_top.sv
tb_ttc_top.sv

/* run.sh */
#!/bin/sh
# Build and run the timer testbench with Verilator, verdict taken from sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ttc_top -f verilog.f -o sim_ttc \
  && ./obj_dir/sim_ttc > sim.log 2>&1 || echo "build or run step failed"
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
